// ==== vlog.f ====
+incdir+testbench
hdl/uart_line_pkg.sv
hdl/echo_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/line_echo_ctrl.sv
hdl/uart_echo_top.sv
testbench/tb_uart_echo.sv

// ==== run.sh ====
#!/bin/sh
# Verilator build and run of the uart line echo testbench
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_uart_echo -f vlog.f -Mdir obj_dir -o sim_uart_echo \
	|| { echo "verilator build failed"; exit 1; }

./obj_dir/sim_uart_echo > sim.log 2>&1 || echo "simulator exited with an error status"
cat sim.log

grep -q "Simulation finished: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "no result line in log"; exit 1; }
echo "simulation passed"

// ==== testbench/tb_line_model.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line echo reference model and tx frame decoder
// expected bytes per line, serial decode of tx_line
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

localparam int KEEP_BYTES = 62;	// payload kept per line
localparam logic [7:0] CR_BYTE = 8'h0D;
localparam logic [7:0] LF_BYTE = 8'h0A;

logic [7:0] exp_q[$];	// expected echo of the current line

// a received byte goes into the line while there is room
task automatic expect_byte(input logic [7:0] data);
	if (exp_q.size() < KEEP_BYTES)
		exp_q.push_back(data);
endtask

// quiet line ends it with CR LF
task automatic close_expected_line();
	exp_q.push_back(CR_BYTE);
	exp_q.push_back(LF_BYTE);
endtask

task automatic check_level(input string sig, input logic exp_val);
	assert (tx_line === exp_val)
		else report_mismatch(sig, exp_val, tx_line);
endtask

// one frame off tx_line, sampled at mid-bit on falling clock edges
task automatic decode_tx_frame(output logic [7:0] data);
	int i;
	do
		@(negedge sys_clk);
	while (tx_line !== 1'b0);
	repeat (BIT_CLKS / 2 - 1) @(negedge sys_clk);	// middle of start bit
	check_level("tx_line start bit", 1'b0);
	for (i = 0; i < uart_line_pkg::DATA_BITS; i++) begin
		repeat (BIT_CLKS) @(negedge sys_clk);
		data[i] = tx_line;	// lsb first
	end
	for (i = 0; i < STOP_BITS; i++) begin
		repeat (BIT_CLKS) @(negedge sys_clk);
		check_level($sformatf("tx_line stop bit %0d", i), 1'b1);
	end
endtask

// compare the decoded echo with the model, byte by byte
task automatic check_echo();
	int i;
	assert (got_q.size() == exp_q.size())
		else report_mismatch("echo byte count", exp_q.size(), got_q.size());
	for (i = 0; i < exp_q.size(); i++) begin
		assert (got_q[i] == exp_q[i])
			else report_mismatch($sformatf("echo byte %0d", i), exp_q[i], got_q[i]);
	end
endtask

// ==== testbench/tb_uart_echo.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart line echo testbench
// random lines in on rx_line, echo decoded off tx_line
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module tb_uart_echo;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_FREQ_HZ = 1_600_000;
	localparam int BAUD_RATE   = 100_000;
	localparam int IDLE_CLKS   = 600;
	localparam int BIT_CLKS    = 16;
	localparam int STOP_BITS   = 2;

	// worst case 10+10+70+10+2 junk+6 frames in and 107 frames out
	localparam int N_LINES      = 5;
	localparam int RX_FRAMES    = 108;
	localparam int TX_FRAMES    = 107;
	localparam int RX_BITS      = 14;	// 10 frame bits plus gap allowance
	localparam int TX_BITS      = 1 + 8 + STOP_BITS;
	localparam int TIMEOUT_CLKS =
		((RX_FRAMES * RX_BITS + TX_FRAMES * TX_BITS) * BIT_CLKS + N_LINES * IDLE_CLKS) * 2;

	logic       sys_clk;
	logic       sys_rst_n;
	logic       rx_line;
	logic       tx_line;
	logic [7:0] line_len;
	logic       echo_busy;

	logic [15:0] lfsr;
	logic [7:0]  got_q[$];	// bytes decoded from tx_line
	logic [7:0]  tx_byte;
	int          cycle_cnt;
	int          len;

	`include "tb_line_model.svh"

	uart_echo_top #(
		.CLK_FREQ_HZ  (CLK_FREQ_HZ),
		.BAUD_RATE    (BAUD_RATE),
		.TX_STOP_BITS (STOP_BITS),
		.IDLE_CLKS    (IDLE_CLKS)
	) dut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_line   (rx_line),
		.tx_line   (tx_line),
		.line_len  (line_len),
		.echo_busy (echo_busy)
	);

	always #10 sys_clk = ~sys_clk;

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_mismatch(input string sig, input logic [31:0] exp_val,
		input logic [31:0] got_val);
		fail_run($sformatf("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h",
			$time, sig, exp_val, got_val));
	endtask

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] next_lfsr(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	endfunction

	task automatic take_bits(input int n, output int val);
		int i;
		val = 0;
		for (i = 0; i < n; i++) begin
			lfsr = next_lfsr(lfsr);
			val = (val << 1) | lfsr[0];
		end
	endtask

	task automatic drive_bit(input logic level);
		@(posedge sys_clk);
		#2 rx_line = level;
		repeat (BIT_CLKS - 1) @(posedge sys_clk);
	endtask

	task automatic idle_clocks(input int n);
		@(posedge sys_clk);
		#2 rx_line = 1'b1;
		repeat (n - 1) @(posedge sys_clk);
	endtask

	// start, 8 data lsb first, one stop at the given level
	task automatic send_frame(input logic [7:0] data, input logic stop_level);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < 8; i++)
			drive_bit(data[i]);
		drive_bit(stop_level);
	endtask

	task automatic wait_busy(input logic level);
		do
			@(negedge sys_clk);
		while (echo_busy !== level);
	endtask

	// one line in, junk bytes during the echo, then compare
	task automatic run_line(input int n_bytes, input int bad_idx, input int n_junk);
		int i;
		int val;
		int gap;
		exp_q.delete();
		got_q.delete();
		for (i = 0; i < n_bytes; i++) begin
			take_bits(8, val);
			take_bits(4, gap);
			if (i == bad_idx) begin
				send_frame(8'(val), 1'b0);	// framing error
				idle_clocks(2 * BIT_CLKS + 4 * gap + 1);
			end else begin
				send_frame(8'(val), 1'b1);
				expect_byte(8'(val));
				idle_clocks(4 * gap + 1);
			end
		end
		close_expected_line();
		wait_busy(1'b1);
		assert (line_len == 8'(exp_q.size()))
			else report_mismatch("line_len", exp_q.size(), line_len);
		for (i = 0; i < n_junk; i++) begin
			take_bits(8, val);
			take_bits(4, gap);
			send_frame(8'(val), 1'b1);
			idle_clocks(4 * gap + 1);
		end
		wait_busy(1'b0);
		check_echo();
	endtask

	// serial monitor
	initial begin
		wait (sys_rst_n === 1'b1);
		forever begin
			decode_tx_frame(tx_byte);
			got_q.push_back(tx_byte);
		end
	end

	// line stays idle outside an echo
	always @(negedge sys_clk) begin
		if (sys_rst_n && !echo_busy)
			assert (tx_line === 1'b1)
				else report_mismatch("tx_line while not busy", 1, tx_line);
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CLKS)
			fail_run($sformatf("timeout: test not done after %0d clock cycles", cycle_cnt));
	end

	initial begin
		sys_clk   = 1'b0;
		sys_rst_n = 1'b0;
		rx_line   = 1'b1;
		lfsr      = 16'd38;
		cycle_cnt = 0;
		repeat (9) @(posedge sys_clk);
		@(negedge sys_clk);
		assert (tx_line === 1'b1) else report_mismatch("tx_line in reset", 1, tx_line);
		assert (line_len === 8'd0) else report_mismatch("line_len in reset", 0, line_len);
		assert (echo_busy === 1'b0) else report_mismatch("echo_busy in reset", 0, echo_busy);
		assert (dut.rx_vld === 1'b0) else report_mismatch("rx_vld in reset", 0, dut.rx_vld);
		assert (dut.tx_req === 1'b0) else report_mismatch("tx_req in reset", 0, dut.tx_req);
		assert (dut.tx_done === 1'b0) else report_mismatch("tx_done in reset", 0, dut.tx_done);
		@(posedge sys_clk);
		#2 sys_rst_n = 1'b1;

		take_bits(3, len);
		run_line(3 + len, -1, 0);	// short line
		take_bits(3, len);
		run_line(3 + len, -1, 0);	// second line after quiet
		run_line(70, -1, 0);	// truncated to 62 plus suffix
		take_bits(3, len);
		run_line(3 + len, -1, 2);	// junk sent during echo
		run_line(6, 2, 0);	// bad stop bit on third byte

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== hdl/uart_echo_top.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart line echo top level
// receiver, line controller and transmitter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module uart_echo_top #(
	parameter int CLK_FREQ_HZ  = 50_000_000,
	parameter int BAUD_RATE    = 115_200,
	parameter int TX_STOP_BITS = 2,
	parameter int IDLE_CLKS    = CLK_FREQ_HZ / 1000	// 1 ms quiet
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       rx_line,
	output logic       tx_line,
	output logic [7:0] line_len,
	output logic       echo_busy
);

	// rounded to the nearest whole clock
	localparam int CLKS_PER_BIT = (CLK_FREQ_HZ + BAUD_RATE / 2) / BAUD_RATE;

	logic [7:0] rx_data;
	logic       rx_vld;
	logic [7:0] tx_data;
	logic       tx_req;
	logic       tx_done;

	uart_rx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart_rx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_line   (rx_line),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld)
	);

	line_echo_ctrl #(
		.IDLE_CLKS (IDLE_CLKS)
	) u_line_echo_ctrl (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld),
		.tx_done   (tx_done),
		.tx_data   (tx_data),
		.tx_req    (tx_req),
		.line_len  (line_len),
		.echo_busy (echo_busy)
	);

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.TX_STOP_BITS (TX_STOP_BITS)
	) u_uart_tx (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_data   (tx_data),
		.tx_req    (tx_req),
		.tx_line   (tx_line),
		.tx_done   (tx_done)
	);

endmodule

// ==== hdl/line_echo_ctrl.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line echo controller
// buffers one line, adds CR LF after an idle gap
// and replays the line through the transmitter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module line_echo_ctrl #(
	parameter int IDLE_CLKS = 50_000
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] rx_data,
	input  logic       rx_vld,
	input  logic       tx_done,
	output logic [7:0] tx_data,
	output logic       tx_req,
	output logic [7:0] line_len,
	output logic       echo_busy
);

	localparam int ADDR_W = $clog2(echo_pkg::BUF_DEPTH);
	localparam int CNT_W  = $clog2(echo_pkg::BUF_DEPTH + 1);
	localparam int IDLE_W = $clog2(IDLE_CLKS + 1);

	localparam logic [CNT_W-1:0]  MAX_CNT  = CNT_W'(echo_pkg::MAX_PAYLOAD);
	localparam logic [IDLE_W-1:0] IDLE_END = IDLE_W'(IDLE_CLKS);

	logic [7:0]            buf_mem [echo_pkg::BUF_DEPTH];
	echo_pkg::echo_state_e state;
	logic [CNT_W-1:0]      wr_cnt;	// bytes in buffer
	logic [CNT_W-1:0]      rd_idx;	// next byte to send
	logic [IDLE_W-1:0]     idle_cnt;
	logic [ADDR_W-1:0]     wr_addr;
	logic                  line_open;
	logic                  byte_take;
	logic                  idle_done;
	logic                  last_sent;

	// idle or finish, an incoming byte opens a fresh line
	assign line_open = (state == echo_pkg::ECHO_IDLE) || (state == echo_pkg::ECHO_FINISH);
	assign byte_take = rx_vld && (line_open ||
		(state == echo_pkg::ECHO_COLLECT && wr_cnt < MAX_CNT));
	assign idle_done = (state == echo_pkg::ECHO_COLLECT) && !rx_vld && (idle_cnt == IDLE_END);
	assign last_sent = (state == echo_pkg::ECHO_SEND) && tx_done && (rd_idx == wr_cnt);
	assign wr_addr   = line_open ? '0 : wr_cnt[ADDR_W-1:0];
	assign echo_busy = (state == echo_pkg::ECHO_SEND);

	always_ff @(posedge sys_clk) begin
		if (byte_take)
			buf_mem[wr_addr] <= rx_data;
		if (idle_done) begin
			buf_mem[wr_addr]               <= echo_pkg::SUFFIX_CR;
			buf_mem[wr_addr + ADDR_W'(1)]  <= echo_pkg::SUFFIX_LF;
		end
	end

	// byte to the transmitter, loaded with each request
	always_ff @(posedge sys_clk) begin
		if (idle_done)
			tx_data <= buf_mem[0];
		else if (state == echo_pkg::ECHO_SEND && tx_done && !last_sent)
			tx_data <= buf_mem[rd_idx[ADDR_W-1:0]];
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= echo_pkg::ECHO_IDLE;
			wr_cnt   <= '0;
			rd_idx   <= '0;
			idle_cnt <= '0;
			tx_req   <= 1'b0;
			line_len <= 8'd0;
		end else begin
			tx_req <= 1'b0;
			case (state)
				echo_pkg::ECHO_IDLE, echo_pkg::ECHO_FINISH: begin
					idle_cnt <= '0;
					rd_idx   <= '0;
					if (byte_take) begin
						wr_cnt <= CNT_W'(1);
						state  <= echo_pkg::ECHO_COLLECT;
					end else begin
						wr_cnt <= '0;	// previous line done
						state  <= echo_pkg::ECHO_IDLE;
					end
				end
				echo_pkg::ECHO_COLLECT: begin
					// any byte on the line restarts the quiet time, kept or not
					if (rx_vld)
						idle_cnt <= '0;
					else if (!idle_done)
						idle_cnt <= idle_cnt + 1'b1;
					if (byte_take)
						wr_cnt <= wr_cnt + 1'b1;
					if (idle_done) begin
						wr_cnt   <= wr_cnt + CNT_W'(2);	// CR LF
						line_len <= 8'(wr_cnt) + 8'd2;
						rd_idx   <= CNT_W'(1);
						tx_req   <= 1'b1;
						state    <= echo_pkg::ECHO_SEND;
					end
				end
				echo_pkg::ECHO_SEND: begin
					if (last_sent)
						state <= echo_pkg::ECHO_FINISH;
					else if (tx_done) begin
						tx_req <= 1'b1;
						rd_idx <= rd_idx + 1'b1;
					end
				end
				default: state <= echo_pkg::ECHO_IDLE;
			endcase
		end
	end

	a_cnt_bound: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wr_cnt <= CNT_W'(echo_pkg::BUF_DEPTH));

	// requests only while replaying, never during collect
	a_req_send: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_req |-> state == echo_pkg::ECHO_SEND);

endmodule

// ==== hdl/uart_tx.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart transmitter
// one byte per request, done in last stop-bit clock
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module uart_tx #(
	parameter int CLKS_PER_BIT = 16,
	parameter int TX_STOP_BITS = 2
) (
	input  logic                                sys_clk,
	input  logic                                sys_rst_n,
	input  logic [uart_line_pkg::DATA_BITS-1:0] tx_data,
	input  logic                                tx_req,
	output logic                                tx_line,
	output logic                                tx_done
);

	localparam int CNT_W  = $clog2(CLKS_PER_BIT);
	localparam int IDX_W  = $clog2(uart_line_pkg::DATA_BITS);
	localparam int STOP_W = $clog2(TX_STOP_BITS + 1);

	localparam logic [CNT_W-1:0]  FULL_BIT  = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [IDX_W-1:0]  LAST_IDX  = IDX_W'(uart_line_pkg::DATA_BITS - 1);
	localparam logic [STOP_W-1:0] LAST_STOP = STOP_W'(TX_STOP_BITS - 1);

	uart_line_pkg::tx_state_e            state;
	logic [CNT_W-1:0]                    clk_cnt;
	logic [IDX_W-1:0]                    bit_idx;
	logic [STOP_W-1:0]                   stop_idx;
	logic [uart_line_pkg::DATA_BITS-1:0] shift_reg;
	logic                                bit_end;

	assign bit_end = (clk_cnt == FULL_BIT);
	assign tx_done = (state == uart_line_pkg::TX_STOP) && bit_end && (stop_idx == LAST_STOP);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= uart_line_pkg::TX_IDLE;
			clk_cnt  <= '0;
			bit_idx  <= '0;
			stop_idx <= '0;
			tx_line  <= uart_line_pkg::STOP_BIT;
		end else begin
			clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
			case (state)
				uart_line_pkg::TX_IDLE: begin
					clk_cnt  <= '0;
					bit_idx  <= '0;
					stop_idx <= '0;
					tx_line  <= uart_line_pkg::STOP_BIT;
					if (tx_req) begin
						tx_line <= uart_line_pkg::START_BIT;	// start bit from next cycle
						state   <= uart_line_pkg::TX_START;
					end
				end
				uart_line_pkg::TX_START: begin
					if (bit_end) begin
						tx_line <= shift_reg[0];
						state   <= uart_line_pkg::TX_DATA;
					end
				end
				uart_line_pkg::TX_DATA: begin
					if (bit_end) begin
						if (bit_idx == LAST_IDX) begin
							tx_line <= uart_line_pkg::STOP_BIT;
							state   <= uart_line_pkg::TX_STOP;
						end else begin
							tx_line <= shift_reg[1];	// next bit before the shift lands
							bit_idx <= bit_idx + 1'b1;
						end
					end
				end
				uart_line_pkg::TX_STOP: begin
					if (bit_end) begin
						if (stop_idx == LAST_STOP)
							state <= uart_line_pkg::TX_IDLE;
						else
							stop_idx <= stop_idx + 1'b1;
					end
				end
				default: state <= uart_line_pkg::TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == uart_line_pkg::TX_IDLE && tx_req)
			shift_reg <= tx_data;
		else if (state == uart_line_pkg::TX_DATA && bit_end)
			shift_reg <= shift_reg >> 1;
	end

	// requester must wait for tx_done before the next byte
	a_req_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_req |-> state == uart_line_pkg::TX_IDLE);

endmodule

// ==== hdl/uart_rx.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart receiver
// mid-bit sampling, start-bit check, stop-bit check
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module uart_rx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic                                sys_clk,
	input  logic                                sys_rst_n,
	input  logic                                rx_line,
	output logic [uart_line_pkg::DATA_BITS-1:0] rx_data,
	output logic                                rx_vld
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT);
	localparam int IDX_W = $clog2(uart_line_pkg::DATA_BITS);

	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(uart_line_pkg::DATA_BITS - 1);

	logic [1:0]                          rx_sync;	// pin synchronizer
	logic                                rx_s;
	uart_line_pkg::rx_state_e            state;
	logic [CNT_W-1:0]                    clk_cnt;
	logic [IDX_W-1:0]                    bit_idx;
	logic [uart_line_pkg::DATA_BITS-1:0] shift_reg;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n)
			rx_sync <= 2'b11;	// line idles high
		else
			rx_sync <= {rx_sync[0], rx_line};
	end

	assign rx_s = rx_sync[1];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state   <= uart_line_pkg::RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			rx_vld  <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			case (state)
				uart_line_pkg::RX_IDLE: begin
					clk_cnt <= '0;
					bit_idx <= '0;
					if (rx_s == uart_line_pkg::START_BIT)
						state <= uart_line_pkg::RX_START;
				end
				uart_line_pkg::RX_START: begin
					if (clk_cnt == HALF_BIT) begin
						clk_cnt <= '0;
						// a short glitch is back high by mid-bit
						if (rx_s == uart_line_pkg::START_BIT)
							state <= uart_line_pkg::RX_DATA;
						else
							state <= uart_line_pkg::RX_IDLE;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				uart_line_pkg::RX_DATA: begin
					if (clk_cnt == FULL_BIT) begin
						clk_cnt <= '0;
						if (bit_idx == LAST_IDX)
							state <= uart_line_pkg::RX_STOP;
						else
							bit_idx <= bit_idx + 1'b1;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				uart_line_pkg::RX_STOP: begin
					if (clk_cnt == FULL_BIT) begin
						clk_cnt <= '0;
						rx_vld  <= (rx_s == uart_line_pkg::STOP_BIT);	// framing error drops byte
						state   <= uart_line_pkg::RX_IDLE;
					end else
						clk_cnt <= clk_cnt + 1'b1;
				end
				default: state <= uart_line_pkg::RX_IDLE;
			endcase
		end
	end

	// data path, lsb arrives first
	always_ff @(posedge sys_clk) begin
		if (state == uart_line_pkg::RX_DATA && clk_cnt == FULL_BIT)
			shift_reg <= {rx_s, shift_reg[uart_line_pkg::DATA_BITS-1:1]};
		if (state == uart_line_pkg::RX_STOP && clk_cnt == FULL_BIT)
			rx_data <= shift_reg;
	end

	// one frame is far longer than a clock, so pulses never merge
	a_vld_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_vld |=> !rx_vld);

endmodule

// ==== hdl/echo_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line echo controller definitions
// buffer sizing, line suffix and controller states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package echo_pkg;

	localparam int BUF_DEPTH = 64;	// bytes per line incl. suffix

	// appended once the line goes quiet
	localparam logic [7:0] SUFFIX_CR = 8'h0D;
	localparam logic [7:0] SUFFIX_LF = 8'h0A;

	// room left for received bytes after the suffix
	localparam int MAX_PAYLOAD = BUF_DEPTH - 2;

	typedef enum logic [1:0] {
		ECHO_IDLE    = 2'd0,	// empty line
		ECHO_COLLECT = 2'd1,	// storing bytes, idle timer running
		ECHO_SEND    = 2'd2,	// replaying buffer to tx
		ECHO_FINISH  = 2'd3
	} echo_state_e;

endpackage

// ==== hdl/uart_line_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// uart serial line format
// frame constants and rx/tx state encodings
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package uart_line_pkg;

	// 8N1 style frame, stop count set per transmitter
	localparam int DATA_BITS = 8;

	localparam logic START_BIT = 1'b0;
	localparam logic STOP_BIT  = 1'b1;	// same level as line idle

	// receiver FSM
	typedef enum logic [1:0] {
		RX_IDLE  = 2'd0,	// waiting for falling edge
		RX_START = 2'd1,	// start bit, checked at mid-bit
		RX_DATA  = 2'd2,
		RX_STOP  = 2'd3
	} rx_state_e;

	// transmitter FSM
	typedef enum logic [1:0] {
		TX_IDLE  = 2'd0,
		TX_START = 2'd1,
		TX_DATA  = 2'd2,	// lsb first
		TX_STOP  = 2'd3		// one or more stop bits
	} tx_state_e;

endpackage
